/* Bender.yml */
package:
  name: kf_wrapper

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/kf_ctrl_pkg.sv
      - logic/kf_data_pkg.sv
      - logic/kf_control.sv
      - logic/kf_word_source.sv
      - logic/kf_block_builder.sv
      - logic/kf_digest_reader.sv
      - logic/kf_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/kf_checker.sv
      - bench/kf_tb.sv

/* bench/kf_checker.sv */
// ----------------------------------------
// K-function control assertions
// Bound to the wrapper top level
// ----------------------------------------
`timescale 1ns/1ps
`include "kf_config.svh"

module kf_checker (
    input logic                     CLK,
    input logic                     RESETN,
    input logic                     keccak_start,
    input logic                     keccak_first,
    input logic                     c0_rden,
    input logic [`KF_C0_ADDR_W-1:0] c0_addr,
    input logic                     k_valid,
    input logic                     done
);

    // Failure count, read by the testbench
    int fails = 0;

    // Start is a single-cycle pulse
    start_pulse: assert property (@(posedge CLK) disable iff (!RESETN)
        keccak_start |=> !keccak_start)
        else begin
            fails++;
            $error("keccak_start held for more than one cycle");
        end

    // Readout never overlaps a permutation start
    kv_vs_start: assert property (@(posedge CLK) disable iff (!RESETN)
        !(k_valid && keccak_start))
        else begin
            fails++;
            $error("k_valid and keccak_start high together");
        end

    // RAM reads stay inside c0
    addr_range: assert property (@(posedge CLK) disable iff (!RESETN)
        c0_rden |-> (c0_addr < `KF_C0_WORDS))
        else begin
            fails++;
            $error("c0_addr out of range");
        end

    // Outputs cleared by a reset cycle
    reset_quiet: assert property (@(posedge CLK)
        !RESETN |=> (!keccak_start && !keccak_first && !c0_rden && !k_valid && !done))
        else begin
            fails++;
            $error("control output high after reset");
        end

endmodule

/* bench/kf_tb.sv */
// ----------------------------------------
// K-function wrapper testbench
// c0 RAM and Keccak models, stream
// model, block and K port checks
// ----------------------------------------
`timescale 1ns/1ps
`include "kf_config.svh"

module kf_tb;

    localparam int TIMEOUT = 2000;
    localparam int BLK_BYTES = 4 * `KF_RATE_WORDS;
    // Longer than one whole run
    localparam int QUIET_CYCLES = 200;

    logic                             CLK = 1'b0;
    logic                             RESETN;
    logic                             hash_en;
    logic [`KF_MSG_BYTES*8-1:0]       m_l;
    logic [`KF_MSG_BYTES*8-1:0]       c1_l;
    kf_data_pkg::kf_word_t            c0_data;
    logic                             keccak_done;
    kf_data_pkg::kf_digest_t          hash_in;
    logic                             done;
    logic                             c0_rden;
    logic [`KF_C0_ADDR_W-1:0]         c0_addr;
    logic                             keccak_start;
    logic                             keccak_first;
    kf_data_pkg::kf_block_t           keccak_m;
    logic                             k_valid;
    logic [$clog2(`KF_K_WORDS)-1:0]   k_addr;
    kf_data_pkg::kf_word_t            k_out;

    // Model state and captures
    kf_data_pkg::kf_word_t            c0_mem [`KF_C0_WORDS];
    kf_data_pkg::kf_word_t            exp_words [`KF_STREAM_WORDS];
    kf_data_pkg::kf_block_t           blocks [`KF_BLOCKS];
    logic                             firsts [`KF_BLOCKS];
    logic [`KF_C0_WORDS-1:0]          addr_seen;
    logic                             rd_pend;
    logic [`KF_C0_ADDR_W-1:0]         addr_pend;
    int                               n_start;
    int                               kc_wait;
    int                               mismatches;
    int                               failures;

    kf_top uut (.*);

    bind kf_top kf_checker u_checker (.*);

    always #2 CLK = ~CLK;

    // ----------------------------------------
    // c0 RAM with one cycle read latency
    // ----------------------------------------
    always @(negedge CLK) begin
        if (rd_pend) begin
            c0_data = c0_mem[addr_pend];
        end
        rd_pend = c0_rden && RESETN && (c0_addr < `KF_C0_WORDS);
        addr_pend = c0_addr;
        if (c0_rden && RESETN) begin
            if (c0_addr < `KF_C0_WORDS) begin
                addr_seen[c0_addr] = 1'b1;
            end else begin
                failures++;
                $display("c0 read at address %0d beyond the RAM at %0t", c0_addr, $time);
            end
        end
    end

    // ----------------------------------------
    // Keccak core with random permutation time
    // ----------------------------------------
    always @(negedge CLK) begin
        keccak_done = 1'b0;
        if (!RESETN) begin
            kc_wait = 0;
        end else if (kc_wait > 0) begin
            if (keccak_start) begin
                failures++;
                $display("keccak_start while the core is still busy at %0t", $time);
            end
            kc_wait--;
            if (kc_wait == 0) begin
                keccak_done = 1'b1;
            end
        end else if (keccak_start) begin
            if (n_start < `KF_BLOCKS) begin
                blocks[n_start] = keccak_m;
                firsts[n_start] = keccak_first;
            end
            n_start++;
            kc_wait = 3 + ($urandom % 8);
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    // Expected bytes are m, c0, c1, then zeros with 06 and 80 pad bytes
    function automatic logic [7:0] stream_byte(input int b);
        logic [7:0] v;
        int c;
        v = 8'h00;
        c = b - `KF_MSG_BYTES;
        if (b < `KF_MSG_BYTES) begin
            v = m_l[8*b +: 8];
        end else if (c < `KF_C0_BYTES) begin
            v = c0_mem[c / 4][8*(c % 4) +: 8];
        end else if (b < `KF_TOTAL_BYTES) begin
            v = c1_l[8*(c - `KF_C0_BYTES) +: 8];
        end
        if (b == `KF_TOTAL_BYTES) begin
            v = v | 8'h06;
        end
        if (b == 4 * `KF_STREAM_WORDS - 1) begin
            v = v | 8'h80;
        end
        return v;
    endfunction

    task automatic load_operands();
        for (int i = 0; i < `KF_K_WORDS; i++) begin
            m_l[32*i +: 32] = $urandom;
            c1_l[32*i +: 32] = $urandom;
            hash_in[32*i +: 32] = $urandom;
        end
        for (int i = 0; i < `KF_C0_WORDS; i++) begin
            c0_mem[i] = $urandom;
        end
        for (int w = 0; w < `KF_STREAM_WORDS; w++) begin
            for (int j = 0; j < 4; j++) begin
                exp_words[w][8*j +: 8] = stream_byte(4*w + j);
            end
        end
        n_start = 0;
        addr_seen = '0;
    endtask

    // ----------------------------------------
    // One full run and its checks
    // ----------------------------------------
    task automatic run_hash(input int run);
        int cyc;
        int kcnt;
        logic kv_prev;
        int pad_off;
        load_operands();
        hash_en = 1'b1;
        @(negedge CLK);
        hash_en = 1'b0;
        cyc = 0;
        kcnt = 0;
        kv_prev = 1'b0;
        // Follow the K port until done
        while (!done && cyc < TIMEOUT) begin
            @(negedge CLK);
            cyc++;
            if (k_valid) begin
                check("k_addr", kcnt, k_addr);
                // Word i is hash bits 255-32i down to 224-32i
                check("k_out", hash_in[`KF_K_WORDS*32-1 - 32*kcnt -: 32], k_out);
                kcnt++;
            end else begin
                check("k_addr_idle", 0, k_addr);
                check("k_out_idle", 0, k_out);
                if (kcnt > 0 && kcnt < `KF_K_WORDS) begin
                    failures++;
                    $display("k_valid dropped after %0d words in run %0d", kcnt, run);
                end
            end
            if (done) begin
                check("k_words_before_done", `KF_K_WORDS, kcnt);
                check("k_valid_before_done", 1, kv_prev);
            end
            kv_prev = k_valid;
        end
        if (!done) begin
            failures++;
            $display("timeout waiting for done in run %0d", run);
        end
        check("keccak_start_count", `KF_BLOCKS, n_start);
        for (int blk = 0; blk < `KF_BLOCKS; blk++) begin
            check("keccak_first", blk == 0, firsts[blk]);
            for (int s = 0; s < `KF_RATE_WORDS; s++) begin
                check($sformatf("block%0d_slot%0d", blk, s),
                      exp_words[blk*`KF_RATE_WORDS + s], blocks[blk][32*s +: 32]);
            end
        end
        // Pad bytes in the final block
        pad_off = `KF_TOTAL_BYTES - (`KF_BLOCKS - 1) * BLK_BYTES;
        check("pad_first_byte", 8'h06, blocks[`KF_BLOCKS-1][8*pad_off +: 8]);
        check("pad_last_byte", 8'h80, blocks[`KF_BLOCKS-1][8*BLK_BYTES-1 -: 8]);
        check("c0_addr_coverage", 1, &addr_seen);
        // done holds while idle
        for (int i = 0; i < 5; i++) begin
            @(negedge CLK);
            check("done_hold", 1, done);
        end
    endtask

    task automatic reset_mid_run();
        int cyc;
        load_operands();
        hash_en = 1'b1;
        @(negedge CLK);
        hash_en = 1'b0;
        cyc = 0;
        // Run is under way once c0 is read
        while (!c0_rden && cyc < TIMEOUT) begin
            @(negedge CLK);
            cyc++;
        end
        if (!c0_rden) begin
            failures++;
            $display("timeout waiting for c0 reads before the mid-run reset");
        end
        RESETN = 1'b0;
        @(negedge CLK);
        check("c0_rden_reset", 0, c0_rden);
        @(negedge CLK);
        RESETN = 1'b1;
        // Cleared sequencer stays quiet without hash_en
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge CLK);
            check("done_after_reset", 0, done);
            check("keccak_start_after_reset", 0, keccak_start);
            check("keccak_first_after_reset", 0, keccak_first);
            check("c0_rden_after_reset", 0, c0_rden);
            check("k_valid_after_reset", 0, k_valid);
        end
    endtask

    initial begin
        void'($urandom(68926));
        RESETN = 1'b0;
        hash_en = 1'b0;
        m_l = '0;
        c1_l = '0;
        c0_data = '0;
        keccak_done = 1'b0;
        hash_in = '0;
        rd_pend = 1'b0;
        addr_pend = '0;
        kc_wait = 0;
        n_start = 0;
        addr_seen = '0;
        mismatches = 0;
        failures = 0;
        repeat (5) @(negedge CLK);
        RESETN = 1'b1;
        @(negedge CLK);
        run_hash(1);
        run_hash(2);
        reset_mid_run();
        failures += uut.u_checker.fails;
        $display("mismatches=%0d failures=%0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+logic
logic/kf_ctrl_pkg.sv
logic/kf_data_pkg.sv
logic/kf_control.sv
logic/kf_word_source.sv
logic/kf_block_builder.sv
logic/kf_digest_reader.sv
logic/kf_top.sv
bench/kf_checker.sv
bench/kf_tb.sv

/* logic/kf_block_builder.sv */
// ----------------------------------------
// K-function block builder
// Stores stream words into the rate block
// register and flags a complete block
// ----------------------------------------
`timescale 1ns/1ps
`include "kf_config.svh"

module kf_block_builder (
    input  logic                         CLK,
    input  logic                         RESETN,
    input  kf_data_pkg::kf_stream_word_t word,
    output kf_data_pkg::kf_block_t       block,
    output logic                         block_ready
);

    kf_data_pkg::kf_block_t block_q;
    logic                   ready_q;

    // Slot write, no reset on block contents
    always_ff @(posedge CLK) begin
        if (word.valid) begin
            block_q[int'(word.slot)*`KF_WORD_W +: `KF_WORD_W] <= word.data;
        end
    end

    // Block complete once the last slot is stored
    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= word.valid && word.last;
        end
    end

    // Register feeds Keccak directly, held until next block starts
    assign block       = block_q;
    assign block_ready = ready_q;

endmodule

/* logic/kf_config.svh */
// ----------------------------------------
// K-function wrapper constants
// Word size, Keccak rate, operand sizes
// and digest layout
// ----------------------------------------
`ifndef KF_CONFIG_SVH
`define KF_CONFIG_SVH

// Stream word and rate block
`define KF_WORD_W        32
`define KF_RATE_WORDS    26

// Message m and ciphertext part c1 share one size
`define KF_MSG_BYTES     32

// Ciphertext part c0, held word-wise in block RAM
`define KF_R_BITS        1234
`define KF_C0_BYTES      ((`KF_R_BITS + 7) / 8)
`define KF_C0_WORDS      ((`KF_C0_BYTES + 3) / 4)
`define KF_C0_ADDR_W     6

// Whole message before padding
`define KF_TOTAL_BYTES   (2 * `KF_MSG_BYTES + `KF_C0_BYTES)

// Rate blocks incl. at least one pad byte
`define KF_BLOCKS        ((`KF_TOTAL_BYTES + 1 + 4 * `KF_RATE_WORDS - 1) / (4 * `KF_RATE_WORDS))
`define KF_STREAM_WORDS  (`KF_BLOCKS * `KF_RATE_WORDS)

// Counter widths
`define KF_IDX_W         7
`define KF_SLOT_W        5

// Hash output, read out word by word
`define KF_K_WORDS       8

`endif

/* logic/kf_control.sv */
// ----------------------------------------
// K-function run sequencer
// Issues word requests per rate block,
// starts Keccak once per block, loops over
// all blocks, then triggers the digest
// readout and holds done
// ----------------------------------------
`timescale 1ns/1ps
`include "kf_config.svh"

module kf_control (
    input  logic                      CLK,
    input  logic                      RESETN,
    input  logic                      hash_en,
    input  logic                      block_ready,
    input  logic                      keccak_done,
    input  logic                      rd_last,
    output kf_ctrl_pkg::kf_word_req_t req,
    output logic                      keccak_start,
    output logic                      keccak_first,
    output logic                      rd_start,
    output logic                      done
);

    localparam int BLK_W = $clog2(`KF_BLOCKS);
    localparam logic [`KF_SLOT_W-1:0] LAST_SLOT = `KF_SLOT_W'(`KF_RATE_WORDS - 1);
    localparam logic [BLK_W-1:0] LAST_BLK = BLK_W'(`KF_BLOCKS - 1);

    kf_ctrl_pkg::kf_state_e state_q;
    kf_ctrl_pkg::kf_state_e state_d;

    // Stream word index, runs across all blocks
    logic [`KF_IDX_W-1:0] idx_q;
    // Slot within the current block
    logic [`KF_SLOT_W-1:0] slot_q;
    // Block being absorbed
    logic [BLK_W-1:0] blk_q;
    logic rd_start_q;

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            // New run from idle or after a finished run
            kf_ctrl_pkg::ST_IDLE,
            kf_ctrl_pkg::ST_DONE: begin
                if (hash_en) begin
                    state_d = kf_ctrl_pkg::ST_ISSUE;
                end
            end
            // One request per cycle, 26 per block
            kf_ctrl_pkg::ST_ISSUE: begin
                if (slot_q == LAST_SLOT) begin
                    state_d = kf_ctrl_pkg::ST_DRAIN;
                end
            end
            // Last word still in the pipe
            kf_ctrl_pkg::ST_DRAIN: begin
                if (block_ready) begin
                    state_d = kf_ctrl_pkg::ST_PERMUTE;
                end
            end
            // Single start cycle
            kf_ctrl_pkg::ST_PERMUTE: begin
                state_d = kf_ctrl_pkg::ST_WAIT;
            end
            kf_ctrl_pkg::ST_WAIT: begin
                if (keccak_done) begin
                    state_d = (blk_q == LAST_BLK) ? kf_ctrl_pkg::ST_READOUT
                                                  : kf_ctrl_pkg::ST_ISSUE;
                end
            end
            // Reader flags its eighth word
            kf_ctrl_pkg::ST_READOUT: begin
                if (rd_last) begin
                    state_d = kf_ctrl_pkg::ST_DONE;
                end
            end
            default: begin
                state_d = kf_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // State and counters
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            state_q    <= kf_ctrl_pkg::ST_IDLE;
            idx_q      <= '0;
            slot_q     <= '0;
            blk_q      <= '0;
            rd_start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Pulse on entry to readout
            rd_start_q <= (state_q == kf_ctrl_pkg::ST_WAIT) &&
                          (state_d == kf_ctrl_pkg::ST_READOUT);
            case (state_q)
                kf_ctrl_pkg::ST_IDLE,
                kf_ctrl_pkg::ST_DONE: begin
                    if (hash_en) begin
                        idx_q  <= '0;
                        slot_q <= '0;
                        blk_q  <= '0;
                    end
                end
                kf_ctrl_pkg::ST_ISSUE: begin
                    idx_q  <= idx_q + 1'b1;
                    slot_q <= (slot_q == LAST_SLOT) ? '0 : slot_q + 1'b1;
                end
                kf_ctrl_pkg::ST_WAIT: begin
                    if (keccak_done && (blk_q != LAST_BLK)) begin
                        blk_q <= blk_q + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Outputs decoded from state
    assign req.valid    = (state_q == kf_ctrl_pkg::ST_ISSUE);
    assign req.index    = idx_q;
    assign req.slot     = slot_q;
    assign keccak_start = (state_q == kf_ctrl_pkg::ST_PERMUTE);
    // Init flag only with the first block of a run
    assign keccak_first = keccak_start && (blk_q == '0);
    assign rd_start     = rd_start_q;
    assign done         = (state_q == kf_ctrl_pkg::ST_DONE);

endmodule

/* logic/kf_ctrl_pkg.sv */
// ----------------------------------------
// K-function control types
// Sequencer states and word requests
// ----------------------------------------
`include "kf_config.svh"

package kf_ctrl_pkg;

    // Run sequencer
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_ISSUE   = 3'd1,
        ST_DRAIN   = 3'd2,
        ST_PERMUTE = 3'd3,
        ST_WAIT    = 3'd4,
        ST_READOUT = 3'd5,
        ST_DONE    = 3'd6
    } kf_state_e;

    // One stream word wanted from the word source
    typedef struct packed {
        logic                   valid;
        // Word number within the padded stream
        logic [`KF_IDX_W-1:0]   index;
        // Target slot within the current rate block
        logic [`KF_SLOT_W-1:0]  slot;
    } kf_word_req_t;

endpackage

/* logic/kf_data_pkg.sv */
// ----------------------------------------
// K-function data types
// Stream words, rate block and digest
// ----------------------------------------
`include "kf_config.svh"

package kf_data_pkg;

    // Little-endian byte packing, byte j in bits 8j+7..8j
    typedef logic [`KF_WORD_W-1:0] kf_word_t;

    // Padded stream word on its way to the block register
    typedef struct packed {
        logic                   valid;
        logic [`KF_SLOT_W-1:0]  slot;
        // Final slot of a block
        logic                   last;
        kf_word_t               data;
    } kf_stream_word_t;

    // Rate part of the Keccak state, slot s in bits 32s+31..32s
    typedef logic [`KF_RATE_WORDS*`KF_WORD_W-1:0] kf_block_t;

    // Hash result handed back by the Keccak core
    typedef logic [`KF_K_WORDS*`KF_WORD_W-1:0] kf_digest_t;

endpackage

/* logic/kf_digest_reader.sv */
// ----------------------------------------
// K-function digest reader
// Steps the hash out as eight words
// with a valid strobe and word address
// ----------------------------------------
`timescale 1ns/1ps
`include "kf_config.svh"

module kf_digest_reader (
    input  logic                                CLK,
    input  logic                                RESETN,
    input  logic                                rd_start,
    input  kf_data_pkg::kf_digest_t             hash_in,
    output logic                                k_valid,
    output logic [$clog2(`KF_K_WORDS)-1:0]      k_addr,
    output kf_data_pkg::kf_word_t               k_out,
    output logic                                rd_last
);

    localparam int AW = $clog2(`KF_K_WORDS);

    logic          active_q;
    logic [AW-1:0] cnt_q;

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (rd_start) begin
            active_q <= 1'b1;
            cnt_q    <= '0;
        end else if (active_q) begin
            cnt_q <= cnt_q + 1'b1;
            // Stop after the final word
            if (cnt_q == AW'(`KF_K_WORDS - 1)) begin
                active_q <= 1'b0;
            end
        end
    end

    // Word 0 is the top slice of the hash
    assign k_valid = active_q;
    assign k_addr  = active_q ? cnt_q : '0;
    assign k_out   = active_q ? hash_in[(`KF_K_WORDS-1-int'(cnt_q))*`KF_WORD_W +: `KF_WORD_W]
                              : '0;
    assign rd_last = active_q && (cnt_q == AW'(`KF_K_WORDS - 1));

endmodule

/* logic/kf_top.sv */
// ----------------------------------------
// K-function wrapper top level
// Builds the padded m | c0 | c1 stream,
// absorbs it through an external Keccak
// core and reads out the hash
// ----------------------------------------
`timescale 1ns/1ps
`include "kf_config.svh"

module kf_top (
    input  logic                              CLK,
    input  logic                              RESETN,
    input  logic                              hash_en,
    output logic                              done,
    // Operands
    input  logic [`KF_MSG_BYTES*8-1:0]        m_l,
    input  logic [`KF_MSG_BYTES*8-1:0]        c1_l,
    // c0 block RAM, 1-cycle read
    output logic                              c0_rden,
    output logic [`KF_C0_ADDR_W-1:0]          c0_addr,
    input  kf_data_pkg::kf_word_t             c0_data,
    // Keccak core
    output logic                              keccak_start,
    output logic                              keccak_first,
    input  logic                              keccak_done,
    output kf_data_pkg::kf_block_t            keccak_m,
    input  kf_data_pkg::kf_digest_t           hash_in,
    // K output
    output logic                              k_valid,
    output logic [$clog2(`KF_K_WORDS)-1:0]    k_addr,
    output kf_data_pkg::kf_word_t             k_out
);

    kf_ctrl_pkg::kf_word_req_t    req;
    kf_data_pkg::kf_stream_word_t word;
    logic                         block_ready;
    logic                         rd_start;
    logic                         rd_last;

    // ----------------------------------------
    kf_control u_control (
        .CLK(CLK), .RESETN(RESETN), .hash_en(hash_en),
        .block_ready(block_ready), .keccak_done(keccak_done), .rd_last(rd_last),
        .req(req), .keccak_start(keccak_start), .keccak_first(keccak_first),
        .rd_start(rd_start), .done(done)
    );

    kf_word_source u_word_source (
        .CLK(CLK), .RESETN(RESETN), .req(req), .m_l(m_l), .c1_l(c1_l),
        .c0_data(c0_data), .c0_rden(c0_rden), .c0_addr(c0_addr), .word(word)
    );

    // Block register is the Keccak rate input
    kf_block_builder u_block_builder (
        .CLK(CLK), .RESETN(RESETN), .word(word),
        .block(keccak_m), .block_ready(block_ready)
    );

    kf_digest_reader u_digest_reader (
        .CLK(CLK), .RESETN(RESETN), .rd_start(rd_start), .hash_in(hash_in),
        .k_valid(k_valid), .k_addr(k_addr), .k_out(k_out), .rd_last(rd_last)
    );

endmodule

/* logic/kf_word_source.sv */
// ----------------------------------------
// K-function word source
// Maps a stream word request onto m, c0,
// c1, SHA-3 padding or zero, byte by byte,
// and emits the word one cycle later
// ----------------------------------------
`timescale 1ns/1ps
`include "kf_config.svh"

module kf_word_source (
    input  logic                           CLK,
    input  logic                           RESETN,
    input  kf_ctrl_pkg::kf_word_req_t      req,
    input  logic [`KF_MSG_BYTES*8-1:0]     m_l,
    input  logic [`KF_MSG_BYTES*8-1:0]     c1_l,
    input  kf_data_pkg::kf_word_t          c0_data,
    output logic                           c0_rden,
    output logic [`KF_C0_ADDR_W-1:0]       c0_addr,
    output kf_data_pkg::kf_stream_word_t   word
);

    localparam int BPW        = `KF_WORD_W / 8;
    // Byte boundaries of the stream sections
    localparam int C0_START   = `KF_MSG_BYTES;
    localparam int C1_START   = `KF_MSG_BYTES + `KF_C0_BYTES;
    localparam int PAD_FIRST  = `KF_TOTAL_BYTES;
    localparam int PAD_LAST   = `KF_STREAM_WORDS * BPW - 1;
    // c0 starts word aligned, so RAM word k is stream word 8+k
    localparam int C0_FIRST_W = C0_START / BPW;
    localparam int C0_LAST_W  = C0_FIRST_W + `KF_C0_WORDS - 1;

    logic [`KF_IDX_W-1:0] c0_off;
    // Bytes known at request time, and byte lanes filled from the RAM
    kf_data_pkg::kf_word_t fixed_d;
    kf_data_pkg::kf_word_t mask_d;
    kf_data_pkg::kf_word_t fixed_q;
    kf_data_pkg::kf_word_t mask_q;
    logic                  valid_q;
    logic                  last_q;
    logic [`KF_SLOT_W-1:0] slot_q;

    // RAM read in the request cycle, seam word included
    assign c0_off  = req.index - `KF_IDX_W'(C0_FIRST_W);
    assign c0_rden = req.valid && (int'(req.index) >= C0_FIRST_W) &&
                     (int'(req.index) <= C0_LAST_W);
    assign c0_addr = c0_off[`KF_C0_ADDR_W-1:0];

    // Per-byte source selection
    always_comb begin
        int b;
        fixed_d = '0;
        mask_d  = '0;
        for (int j = 0; j < BPW; j++) begin
            b = int'(req.index) * BPW + j;
            if (b < C0_START) begin
                fixed_d[8*j +: 8] = m_l[8*b +: 8];
            end else if (b < C1_START) begin
                mask_d[8*j +: 8] = 8'hff;
            end else if (b < PAD_FIRST) begin
                // c1 bytes shifted past the unaligned c0 tail
                fixed_d[8*j +: 8] = c1_l[8*(b - C1_START) +: 8];
            end
            // Domain bits 06, final bit 80, may share one byte
            if (b == PAD_FIRST) begin
                fixed_d[8*j +: 8] = fixed_d[8*j +: 8] | 8'h06;
            end
            if (b == PAD_LAST) begin
                fixed_d[8*j +: 8] = fixed_d[8*j +: 8] | 8'h80;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
        end
    end

    // Payload stage
    always_ff @(posedge CLK) begin
        slot_q  <= req.slot;
        last_q  <= (req.slot == `KF_SLOT_W'(`KF_RATE_WORDS - 1));
        fixed_q <= fixed_d;
        mask_q  <= mask_d;
    end

    // RAM data lands now, merge into its lanes
    always_comb begin
        word.valid = valid_q;
        word.slot  = slot_q;
        word.last  = last_q;
        word.data  = fixed_q | (c0_data & mask_q);
    end

endmodule
